/* hdl/cache_geom_pkg.sv */
// cache geometry
`default_nettype none

package cache_geom_pkg;

	localparam int addr_width = 32;
	localparam int line_width = 64;
	localparam int offset_bits = 3;

	localparam int num_sets = 8;
	localparam int set_bits = 3;
	localparam int num_ways = 4;
	localparam int way_bits = 2;

	// whatever is left above the index and offset
	localparam int tag_bits = addr_width - set_bits - offset_bits;

	// one bit per inner node of a binary tree over the ways
	localparam int plru_bits = num_ways - 1;

	// same address bits seen whole or split into tag, set and offset
	typedef union packed {
		logic [addr_width-1:0] word;
		struct packed {
			logic [tag_bits-1:0] tag;
			logic [set_bits-1:0] set;
			logic [offset_bits-1:0] offset;
		} fields;
	} cache_addr_u;

endpackage

`default_nettype wire

/* hdl/writeback_pkg.sv */
// write-back link
`default_nettype none

package writeback_pkg;

	// victim queue
	localparam int victim_depth = 4;
	localparam int victim_count_bits = 3;

	// credits memory grants at reset
	localparam int wb_credits = 2;
	localparam int credit_bits = 2;

endpackage

`default_nettype wire

/* hdl/plru_tree.sv */
// tree pseudo-LRU
`default_nettype none

module plru_tree import cache_geom_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic rd_touch,
	input wire logic [set_bits-1:0] rd_set,
	input wire logic [way_bits-1:0] rd_way,
	input wire logic wr_touch,
	input wire logic [set_bits-1:0] wr_set,
	input wire logic [way_bits-1:0] wr_way,
	input wire logic [set_bits-1:0] query_set,
	output logic [way_bits-1:0] victim_way
);

	logic [plru_bits-1:0] plru [num_sets];
	logic [plru_bits-1:0] plru_next [num_sets];

	// point every node on the path away from the touched way
	function automatic logic [plru_bits-1:0] touch(input logic [plru_bits-1:0] bits,
			input logic [way_bits-1:0] way);
		logic [plru_bits-1:0] result;
		result = bits;
		result[0] = ~way[1];
		if (way[1])
			result[2] = ~way[0];
		else
			result[1] = ~way[0];
		return result;
	endfunction

	// write first, then the read on top of it
	always_comb begin
		plru_next = plru;
		if (wr_touch)
			plru_next[wr_set] = touch(plru_next[wr_set], wr_way);
		if (rd_touch)
			plru_next[rd_set] = touch(plru_next[rd_set], rd_way);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_sets; i++)
				plru[i] <= '0;
		end else begin
			plru <= plru_next;
		end
	end

	// root picks the half, the child picks the way
	assign victim_way = plru[query_set][0] ? {1'b1, plru[query_set][2]} :
		{1'b0, plru[query_set][1]};

endmodule

`default_nettype wire

/* hdl/cache_sets.sv */
// set-associative line store
`default_nettype none

module cache_sets import cache_geom_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic rd_en,
	input wire cache_addr_u rd_addr,
	input wire logic wr_en,
	input wire cache_addr_u wr_addr,
	input wire logic [line_width-1:0] wr_data,
	input wire logic victim_space,
	output logic rd_hit,
	output logic [line_width-1:0] rd_data,
	output logic wr_ready,
	output logic victim_push,
	output cache_addr_u victim_addr,
	output logic [line_width-1:0] victim_data
);

	logic [tag_bits-1:0] tags [num_sets][num_ways];
	logic [line_width-1:0] lines [num_sets][num_ways];
	logic [num_ways-1:0] valid [num_sets];

	logic [set_bits-1:0] rd_set;
	logic [set_bits-1:0] wr_set;
	logic [num_ways-1:0] rd_match;
	logic [num_ways-1:0] wr_match;
	logic [way_bits-1:0] rd_way;
	logic [way_bits-1:0] hit_way;
	logic [way_bits-1:0] free_way;
	logic [way_bits-1:0] plru_way;
	logic [way_bits-1:0] wr_way;
	logic wr_fire;
	logic set_full;

	assign rd_set = rd_addr.fields.set;
	assign wr_set = wr_addr.fields.set;

	// parallel tag compare across the indexed set
	always_comb begin
		rd_way = '0;
		hit_way = '0;
		free_way = '0;
		for (int i = 0; i < num_ways; i++) begin
			rd_match[i] = valid[rd_set][i] && tags[rd_set][i] == rd_addr.fields.tag;
			wr_match[i] = valid[wr_set][i] && tags[wr_set][i] == wr_addr.fields.tag;
			if (rd_match[i])
				rd_way = way_bits'(i);
			if (wr_match[i])
				hit_way = way_bits'(i);
		end
		// scan downward so the lowest invalid way wins
		for (int i = num_ways - 1; i >= 0; i--) begin
			if (!valid[wr_set][i])
				free_way = way_bits'(i);
		end
	end

	assign rd_hit = rd_en && (|rd_match);
	assign rd_data = lines[rd_set][rd_way];

	// every write may evict, so only take one when the queue has room
	assign wr_ready = victim_space;
	assign wr_fire = wr_en && wr_ready;
	assign set_full = &valid[wr_set];

	always_comb begin
		if (|wr_match)
			wr_way = hit_way;
		else if (!set_full)
			wr_way = free_way;
		else
			wr_way = plru_way;
	end

	assign victim_push = wr_fire && !(|wr_match) && set_full;
	assign victim_data = lines[wr_set][plru_way];

	always_comb begin
		victim_addr.fields.tag = tags[wr_set][plru_way];
		victim_addr.fields.set = wr_set;
		victim_addr.fields.offset = '0;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < num_sets; i++)
				valid[i] <= '0;
		end else if (wr_fire) begin
			valid[wr_set][wr_way] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_fire) begin
			tags[wr_set][wr_way] <= wr_addr.fields.tag;
			lines[wr_set][wr_way] <= wr_data;
		end
	end

	plru_tree plru (
		.clock(clock),
		.reset(reset),
		.rd_touch(rd_hit),
		.rd_set(rd_set),
		.rd_way(rd_way),
		.wr_touch(wr_fire),
		.wr_set(wr_set),
		.wr_way(wr_way),
		.query_set(wr_set),
		.victim_way(plru_way)
	);

endmodule

`default_nettype wire

/* hdl/victim_fifo.sv */
// victim queue
`default_nettype none

module victim_fifo import cache_geom_pkg::*, writeback_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic push,
	input wire cache_addr_u push_addr,
	input wire logic [line_width-1:0] push_data,
	input wire logic pop,
	output logic space,
	output logic head_valid,
	output cache_addr_u head_addr,
	output logic [line_width-1:0] head_data
);

	cache_addr_u addr_mem [victim_depth];
	logic [line_width-1:0] data_mem [victim_depth];

	// depth is a power of two so the pointers wrap on their own
	logic [victim_count_bits-2:0] wr_ptr;
	logic [victim_count_bits-2:0] rd_ptr;
	logic [victim_count_bits-1:0] count;
	logic do_push;
	logic do_pop;

	assign space = count != victim_count_bits'(victim_depth);
	assign head_valid = count != '0;
	assign do_push = push && space;
	assign do_pop = pop && head_valid;

	// show-ahead head
	assign head_addr = addr_mem[rd_ptr];
	assign head_data = data_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			addr_mem[wr_ptr] <= push_addr;
			data_mem[wr_ptr] <= push_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/writeback_port.sv */
// credited write-back port
`default_nettype none

module writeback_port import cache_geom_pkg::*, writeback_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic head_valid,
	input wire cache_addr_u head_addr,
	input wire logic [line_width-1:0] head_data,
	input wire logic credit_return,
	output logic pop,
	output logic wb_valid,
	output logic [addr_width-1:0] wb_addr,
	output logic [line_width-1:0] wb_data
);

	logic [credit_bits-1:0] credits;
	logic issue;

	// one credit per beat, memory never refuses
	assign issue = head_valid && credits != '0;
	assign pop = issue;

	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= credit_bits'(wb_credits);
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= issue;
			case ({issue, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			wb_addr <= head_addr.word;
			wb_data <= head_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/cache_subsystem.sv */
// data cache with victim write-back
`default_nettype none

module cache_subsystem import cache_geom_pkg::*; (
	input wire logic clock,
	input wire logic reset,
	input wire logic rd_en,
	input wire cache_addr_u rd_addr,
	input wire logic wr_en,
	input wire cache_addr_u wr_addr,
	input wire logic [line_width-1:0] wr_data,
	input wire logic credit_return,
	output logic rd_hit,
	output logic [line_width-1:0] rd_data,
	output logic wr_ready,
	output logic wb_valid,
	output logic [addr_width-1:0] wb_addr,
	output logic [line_width-1:0] wb_data
);

	logic victim_push;
	cache_addr_u victim_addr;
	logic [line_width-1:0] victim_data;
	logic victim_space;
	logic head_valid;
	cache_addr_u head_addr;
	logic [line_width-1:0] head_data;
	logic pop;

	cache_sets sets (
		.clock(clock),
		.reset(reset),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.victim_space(victim_space),
		.rd_hit(rd_hit),
		.rd_data(rd_data),
		.wr_ready(wr_ready),
		.victim_push(victim_push),
		.victim_addr(victim_addr),
		.victim_data(victim_data)
	);

	victim_fifo victims (
		.clock(clock),
		.reset(reset),
		.push(victim_push),
		.push_addr(victim_addr),
		.push_data(victim_data),
		.pop(pop),
		.space(victim_space),
		.head_valid(head_valid),
		.head_addr(head_addr),
		.head_data(head_data)
	);

	writeback_port wb_port (
		.clock(clock),
		.reset(reset),
		.head_valid(head_valid),
		.head_addr(head_addr),
		.head_data(head_data),
		.credit_return(credit_return),
		.pop(pop),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

/* sim/cache_ref_model.svh */
// cache reference model
`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

logic [tag_bits-1:0] m_tag [num_sets][num_ways];
logic [line_width-1:0] m_data [num_sets][num_ways];
logic m_valid [num_sets][num_ways];
logic [plru_bits-1:0] m_plru [num_sets];

// victims in eviction order
logic [addr_width-1:0] q_addr [$];
logic [line_width-1:0] q_data [$];

int m_credits;
bit m_wb_valid;
logic [addr_width-1:0] m_wb_addr;
logic [line_width-1:0] m_wb_data;

function automatic void clear_model();
	for (int s = 0; s < num_sets; s++) begin
		m_plru[s] = '0;
		for (int w = 0; w < num_ways; w++)
			m_valid[s][w] = 1'b0;
	end
	q_addr.delete();
	q_data.delete();
	m_credits = wb_credits;
	m_wb_valid = 1'b0;
endfunction

// a set bit sends the victim to the right, touching points every node away
function automatic logic [plru_bits-1:0] touch_way(input logic [plru_bits-1:0] bits,
		input int way);
	logic [plru_bits-1:0] b;
	b = bits;
	if (way < 2) begin
		b[0] = 1'b1;
		b[1] = (way == 0);
	end else begin
		b[0] = 1'b0;
		b[2] = (way == 2);
	end
	return b;
endfunction

function automatic int pick_victim(input logic [plru_bits-1:0] bits);
	if (bits[0])
		return bits[2] ? 3 : 2;
	return bits[1] ? 1 : 0;
endfunction

// way holding the tag, or -1 on a miss
function automatic int find_line(input int s, input logic [tag_bits-1:0] t);
	for (int w = 0; w < num_ways; w++) begin
		if (m_valid[s][w] && m_tag[s][w] == t)
			return w;
	end
	return -1;
endfunction

// hit way, else lowest invalid way, else the PLRU victim which is queued
function automatic int install_line(input int s, input logic [tag_bits-1:0] t,
		input logic [line_width-1:0] d);
	int w;
	w = find_line(s, t);
	if (w < 0) begin
		for (int i = num_ways - 1; i >= 0; i--) begin
			if (!m_valid[s][i])
				w = i;
		end
	end
	if (w < 0) begin
		w = pick_victim(m_plru[s]);
		q_addr.push_back({m_tag[s][w], set_bits'(s), offset_bits'(0)});
		q_data.push_back(m_data[s][w]);
	end
	m_tag[s][w] = t;
	m_data[s][w] = d;
	m_valid[s][w] = 1'b1;
	return w;
endfunction

`endif

/* sim/cache_tb.sv */
// cache subsystem testbench
`default_nettype none

module cache_tb
	import cache_geom_pkg::*, writeback_pkg::*;
();

	localparam int num_ops = 2000;
	localparam int cycle_limit = num_ops * 4 + 200;
	localparam int tags_per_set = 6;
	localparam logic [tag_bits-1:0] tag_base = 26'h2b5_c3a1;
	localparam logic [tag_bits-1:0] tag_step = 26'h013_5790;

	logic clock;
	logic reset;
	logic rd_en;
	cache_addr_u rd_addr;
	logic wr_en;
	cache_addr_u wr_addr;
	logic [line_width-1:0] wr_data;
	logic credit_return;
	logic rd_hit;
	logic [line_width-1:0] rd_data;
	logic wr_ready;
	logic wb_valid;
	logic [addr_width-1:0] wb_addr;
	logic [line_width-1:0] wb_data;

	logic [31:0] lcg_state;
	int cycles;
	// beats seen by memory and not yet credited back
	int owed;
	// cycles left in a burst of withheld credits
	int hold;

	`include "cache_ref_model.svh"

	cache_subsystem dut (
		.clock(clock),
		.reset(reset),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.credit_return(credit_return),
		.rd_hit(rd_hit),
		.rd_data(rd_data),
		.wr_ready(wr_ready),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// six tags per set keep hits, fills and evictions all in play
	function automatic cache_addr_u random_addr();
		cache_addr_u a;
		logic [31:0] r;
		r = next_rand();
		a.fields.set = r[31:29];
		a.fields.offset = r[28:26];
		a.fields.tag = tag_base + tag_bits'((r[25:18] % tags_per_set) * tag_step);
		return a;
	endfunction

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("Fail at time %0t: %s expected %h actual %h", $time, name,
				expected, actual);
			abort_run();
		end
	endtask

	task automatic drive_stimulus(input bit writes_on);
		logic [31:0] r;
		r = next_rand();
		rd_en <= r[31:30] != 2'b00;
		rd_addr <= random_addr();
		wr_en <= writes_on && r[29:28] != 2'b00;
		wr_addr <= random_addr();
		wr_data <= {next_rand(), next_rand()};
		if (hold > 0) begin
			hold--;
			credit_return <= 1'b0;
		end else if (r[27:24] == 4'h0) begin
			hold = 8 + r[20:16];
			credit_return <= 1'b0;
		end else if (owed > 0 && r[23]) begin
			owed--;
			credit_return <= 1'b1;
		end else begin
			credit_return <= 1'b0;
		end
	endtask

	task automatic check_outputs();
		int w;
		w = find_line(rd_addr.fields.set, rd_addr.fields.tag);
		compare("rd_hit", rd_en && w >= 0, rd_hit);
		if (rd_en && w >= 0)
			compare("rd_data", m_data[rd_addr.fields.set][w], rd_data);
		compare("wr_ready", q_addr.size() < victim_depth, wr_ready);
		compare("wb_valid", m_wb_valid, wb_valid);
		if (m_wb_valid) begin
			compare("wb_addr", m_wb_addr, wb_addr);
			compare("wb_data", m_wb_data, wb_data);
		end
	endtask

	// model state after the coming edge
	task automatic advance();
		int rw;
		int ww;
		int s;
		bit accept;
		bit issue;
		s = wr_addr.fields.set;
		rw = rd_en ? find_line(rd_addr.fields.set, rd_addr.fields.tag) : -1;
		accept = wr_en && q_addr.size() < victim_depth;
		issue = q_addr.size() > 0 && m_credits > 0;
		m_wb_valid = issue;
		if (issue) begin
			m_wb_addr = q_addr.pop_front();
			m_wb_data = q_data.pop_front();
		end
		m_credits = m_credits - issue + credit_return;
		// write touches the tree before the read does
		if (accept) begin
			ww = install_line(s, wr_addr.fields.tag, wr_data);
			m_plru[s] = touch_way(m_plru[s], ww);
		end
		if (rw >= 0)
			m_plru[rd_addr.fields.set] = touch_way(m_plru[rd_addr.fields.set], rw);
	endtask

	task automatic run_cycle(input bit writes_on);
		@(posedge clock);
		drive_stimulus(writes_on);
		@(negedge clock);
		check_outputs();
		if (wb_valid)
			owed++;
		advance();
	endtask

	always @(posedge clock) begin
		if (!reset) begin
			cycles++;
			if (cycles >= cycle_limit) begin
				$display("timeout: run not finished after %0d cycles, %0d victims queued",
					cycle_limit, q_addr.size());
				abort_run();
			end
		end
	end

	initial begin
		lcg_state = 32'h55e7_5939;
		clock = 1'b0;
		reset = 1'b1;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		credit_return = 1'b0;
		cycles = 0;
		owed = 0;
		hold = 0;
		clear_model();
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		rd_en <= 1'b1;
		rd_addr <= random_addr();
		// empty cache right after reset
		@(negedge clock);
		compare("rd_hit", 1'b0, rd_hit);
		compare("wb_valid", 1'b0, wb_valid);
		compare("wr_ready", 1'b1, wr_ready);
		for (int op = 0; op < num_ops; op++)
			run_cycle(1'b1);
		// writes off, keep going until every victim has left
		while (q_addr.size() > 0 || m_wb_valid)
			run_cycle(1'b0);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+sim
hdl/cache_geom_pkg.sv
hdl/writeback_pkg.sv
hdl/plru_tree.sv
hdl/cache_sets.sv
hdl/victim_fifo.sv
hdl/writeback_port.sv
hdl/cache_subsystem.sv
sim/cache_tb.sv

/* Bender.yml */
package:
  name: cache_subsystem

sources:
  - files:
      - hdl/cache_geom_pkg.sv
      - hdl/writeback_pkg.sv
      - hdl/plru_tree.sv
      - hdl/cache_sets.sv
      - hdl/victim_fifo.sv
      - hdl/writeback_port.sv
      - hdl/cache_subsystem.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cache_tb.sv
